// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // register index, rs1 rs2 and rd fields
    typedef logic [4:0] reg_addr_t;

    // integer register count, x0 included
    localparam int num_regs = 32;

    // major opcodes of the supported subset
    // upper immediate classes
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;

    // jumps
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;

    // register-immediate arithmetic, only addi kept
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // register-register arithmetic, only add kept
    localparam logic [6:0] opc_op = 7'b0110011;

    // funct3 zero
    // shared by add, addi and jalr
    localparam logic [2:0] f3_add = 3'b000;

    // funct7 of add, sub would set bit 5
    localparam logic [6:0] f7_add = 7'b0000000;

    // full ebreak word, system opcode with imm 1
    localparam logic [31:0] inst_ebreak = 32'h00100073;

endpackage

// File: rtl/core_cfg_pkg.sv
package core_cfg_pkg;

    // data and address width
    localparam int xlen = 32;

    // one machine word
    typedef logic [xlen-1:0] word_t;

    // first fetch address after reset
    localparam word_t reset_pc = 32'h8000_0000;

    // fetch queue entries, power of two
    localparam int queue_depth = 4;

    // pointer width for the fetch queue
    localparam int queue_ptr_w = $clog2(queue_depth);

    // one fetched word with the pc it came from
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_entry_t;

endpackage

// File: rtl/fetch_queue_if.sv
`timescale 1ns/1ps

interface fetch_queue_if;

    // producer side
    logic push;
    core_cfg_pkg::fetch_entry_t push_entry;
    logic full;

    // consumer side
    logic pop;
    logic flush;
    core_cfg_pkg::fetch_entry_t head;
    logic empty;

    // fetch unit
    modport producer (
        output push,
        output push_entry,
        input  full
    );

    // the queue itself
    modport buffer (
        input  push,
        input  push_entry,
        output full,
        input  pop,
        input  flush,
        output head,
        output empty
    );

    // execute unit
    modport consumer (
        output pop,
        output flush,
        input  head,
        input  empty
    );

endinterface

// File: rtl/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch (
    input  logic                clk,
    input  logic                rst_n,
    fetch_queue_if.producer     q,
    input  logic                redirect,
    input  core_cfg_pkg::word_t redirect_pc,
    input  logic                halt,
    output core_cfg_pkg::word_t imem_addr,
    input  core_cfg_pkg::word_t imem_rdata
);

    // fetch pc
    core_cfg_pkg::word_t pc;

    // low in the first cycle out of reset
    logic running;

    // push condition
    logic do_push;

    // program memory answers in the same cycle
    assign imem_addr = pc;

    // room in queue, core alive, no redirect pending
    assign do_push = running && !q.full && !halt && !redirect;

    assign q.push = do_push;

    // entry pairs the word with its address
    assign q.push_entry = '{pc: pc, inst: imem_rdata};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= core_cfg_pkg::reset_pc;
        end else if (redirect) begin
            // jump target wins over sequential step
            pc <= redirect_pc;
        end else if (do_push) begin
            // next word only once this one is queued
            pc <= pc + 32'd4;
        end
    end

    // pc stays word aligned
    assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

// File: rtl/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic          clk,
    input  logic          rst_n,
    fetch_queue_if.buffer q
);

    // entry storage, no reset
    core_cfg_pkg::fetch_entry_t mem [core_cfg_pkg::queue_depth];

    // circular pointers
    logic [core_cfg_pkg::queue_ptr_w-1:0] wr_ptr;
    logic [core_cfg_pkg::queue_ptr_w-1:0] rd_ptr;

    // occupancy, one extra bit for the full case
    logic [core_cfg_pkg::queue_ptr_w:0] count;

    // full and empty straight from the count
    assign q.full = (count == (core_cfg_pkg::queue_ptr_w + 1)'(core_cfg_pkg::queue_depth));
    assign q.empty = (count == '0);

    // oldest entry
    assign q.head = mem[rd_ptr];

    // write slot
    // a flushed push is dropped
    always_ff @(posedge clk) begin
        if (q.push && !q.flush) begin
            mem[wr_ptr] <= q.push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || q.flush) begin
            // flush also drops the push and pop of this cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (q.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // count moves only when one side acts alone
            case ({q.push, q.pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fetch unit honours full
    assert property (@(posedge clk) disable iff (!rst_n)
        q.push |-> !q.full);

    // execute unit honours empty
    assert property (@(posedge clk) disable iff (!rst_n)
        q.pop |-> !q.empty);

endmodule

// File: rtl/int_regfile.sv
`timescale 1ns/1ps

module int_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  rv_isa_pkg::reg_addr_t waddr,
    input  core_cfg_pkg::word_t   wdata,
    input  rv_isa_pkg::reg_addr_t raddr1,
    output core_cfg_pkg::word_t   rdata1,
    input  rv_isa_pkg::reg_addr_t raddr2,
    output core_cfg_pkg::word_t   rdata2
);

    // x0 to x31
    core_cfg_pkg::word_t regs [rv_isa_pkg::num_regs];

    // combinational reads
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            // x0 writes fall away here
            regs[waddr] <= wdata;
        end
    end

    // x0 stays zero whatever the execute unit sends
    assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0);

endmodule

// File: rtl/rv_exec.sv
`timescale 1ns/1ps

module rv_exec (
    input  logic                  clk,
    input  logic                  rst_n,
    fetch_queue_if.consumer       q,
    input  logic                  run,
    output logic                  redirect,
    output core_cfg_pkg::word_t   redirect_pc,
    output logic                  rf_wen,
    output rv_isa_pkg::reg_addr_t rf_waddr,
    output core_cfg_pkg::word_t   rf_wdata,
    output rv_isa_pkg::reg_addr_t rf_raddr1,
    input  core_cfg_pkg::word_t   rf_rdata1,
    output rv_isa_pkg::reg_addr_t rf_raddr2,
    input  core_cfg_pkg::word_t   rf_rdata2,
    output logic                  retire,
    output core_cfg_pkg::word_t   retire_pc,
    output rv_isa_pkg::reg_addr_t retire_rd,
    output core_cfg_pkg::word_t   retire_wdata,
    output logic                  halt,
    output logic                  illegal
);

    // instruction fields
    core_cfg_pkg::word_t   inst, pc;
    logic [6:0]            opcode, funct7;
    logic [2:0]            funct3;
    logic [7:0]            hot_funct3;
    rv_isa_pkg::reg_addr_t rd;
    // class selects
    logic is_i, is_u, is_j, is_r;
    // one-hot operation selects
    logic is_lui, is_auipc, is_jal, is_jalr, is_addi, is_add, is_ebreak;
    logic bad_op, fire, halted;
    // immediates and results
    core_cfg_pkg::word_t imm_i, imm_u, imm_j, imm;
    core_cfg_pkg::word_t link, rs1_sum, wdata;

    assign inst = q.head.inst;
    assign pc   = q.head.pc;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign hot_funct3 = 8'b1 << funct3;

    // opcode classes
    assign is_i = (opcode == rv_isa_pkg::opc_op_imm) || (opcode == rv_isa_pkg::opc_jalr);
    assign is_u = (opcode == rv_isa_pkg::opc_lui) || (opcode == rv_isa_pkg::opc_auipc);
    assign is_j = (opcode == rv_isa_pkg::opc_jal);
    assign is_r = (opcode == rv_isa_pkg::opc_op);

    // operations
    assign is_lui    = is_u && opcode[5];
    assign is_auipc  = is_u && !opcode[5];
    assign is_jal    = is_j;
    assign is_jalr   = is_i && opcode[6] && hot_funct3[rv_isa_pkg::f3_add];
    assign is_addi   = is_i && !opcode[6] && hot_funct3[rv_isa_pkg::f3_add];
    assign is_add    = is_r && hot_funct3[rv_isa_pkg::f3_add] && (funct7 == rv_isa_pkg::f7_add);
    assign is_ebreak = (inst == rv_isa_pkg::inst_ebreak);

    // anything else stops the core as illegal
    assign bad_op = !(is_lui || is_auipc || is_jal || is_jalr || is_addi || is_add || is_ebreak);

    // sign-extended immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // only one class active at a time
    assign imm = ({core_cfg_pkg::xlen{is_i}} & imm_i)
               | ({core_cfg_pkg::xlen{is_u}} & imm_u)
               | ({core_cfg_pkg::xlen{is_j}} & imm_j);

    assign link    = pc + 32'd4;
    // addi result and jalr target base
    assign rs1_sum = rf_rdata1 + imm;

    assign wdata = ({core_cfg_pkg::xlen{is_lui}} & imm)
                 | ({core_cfg_pkg::xlen{is_auipc}} & (pc + imm))
                 | ({core_cfg_pkg::xlen{is_jal || is_jalr}} & link)
                 | ({core_cfg_pkg::xlen{is_addi}} & rs1_sum)
                 | ({core_cfg_pkg::xlen{is_add}} & (rf_rdata1 + rf_rdata2));

    // one instruction per cycle when allowed
    assign fire  = run && !q.empty && !halted;
    assign q.pop = fire;

    // register file
    assign rf_raddr1 = inst[19:15];
    assign rf_raddr2 = inst[24:20];
    assign rf_waddr  = rd;
    assign rf_wdata  = wdata;
    // ebreak and illegal write nothing
    assign rf_wen    = fire && !is_ebreak && !bad_op;

    // jumps steer fetch and drop the wrong path
    assign redirect    = fire && (is_jal || is_jalr);
    assign q.flush     = redirect;
    assign redirect_pc = is_jalr ? {rs1_sum[31:1], 1'b0} : (pc + imm_j);

    // sticky stop state until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted  <= 1'b0;
            illegal <= 1'b0;
            retire  <= 1'b0;
        end else begin
            if (fire && (is_ebreak || bad_op)) begin
                halted <= 1'b1;
            end
            if (fire && bad_op) begin
                illegal <= 1'b1;
            end
            // illegal word never retires
            retire <= fire && !bad_op;
        end
    end

    // retire payload held between strobes
    // the ebreak word has rd zero and selects no result
    always_ff @(posedge clk) begin
        if (fire) begin
            retire_pc    <= pc;
            retire_rd    <= rd;
            retire_wdata <= wdata;
        end
    end

    // halt covers ebreak and illegal stops
    assign halt = halted;

    // jump targets land on word boundaries
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

// File: rtl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    output core_cfg_pkg::word_t   imem_addr,
    input  core_cfg_pkg::word_t   imem_rdata,
    input  logic                  run,
    output logic                  retire,
    output core_cfg_pkg::word_t   retire_pc,
    output rv_isa_pkg::reg_addr_t retire_rd,
    output core_cfg_pkg::word_t   retire_wdata,
    output logic                  halt,
    output logic                  illegal
);

    // fetch to execute path
    fetch_queue_if u_q ();

    // jump path back to fetch
    logic                redirect;
    core_cfg_pkg::word_t redirect_pc;

    // register file ports
    logic                  rf_wen;
    rv_isa_pkg::reg_addr_t rf_waddr, rf_raddr1, rf_raddr2;
    core_cfg_pkg::word_t   rf_wdata, rf_rdata1, rf_rdata2;

    inst_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .q           (u_q.producer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halt        (halt),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata)
    );

    fetch_queue u_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (u_q.buffer)
    );

    rv_exec u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .q            (u_q.consumer),
        .run          (run),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .rf_wen       (rf_wen),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .rf_raddr1    (rf_raddr1),
        .rf_rdata1    (rf_rdata1),
        .rf_raddr2    (rf_raddr2),
        .rf_rdata2    (rf_rdata2),
        .retire       (retire),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .halt         (halt),
        .illegal      (illegal)
    );

    int_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2)
    );

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int clk_period = 20;
    // seven runs, each program at most max_words long
    localparam int num_runs = 7;
    localparam int max_words = 64;
    localparam int cycles_per_word = 16;
    localparam int run_overhead = 40;
    localparam int watchdog_ns =
        num_runs * (max_words * cycles_per_word + run_overhead) * clk_period;

    logic clk, rst_n, run;
    core_cfg_pkg::word_t imem_addr, imem_rdata, retire_pc, retire_wdata;
    rv_isa_pkg::reg_addr_t retire_rd;
    logic retire, halt, illegal;

    // program image, word 0 at reset_pc
    logic [31:0] prog [256];
    int prog_len = 0;
    logic [31:0] imem_off;

    // model output, consumed in retire order
    logic [31:0] exp_pc [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_wdata [$];
    logic exp_illegal;

    logic [31:0] lcg_state;
    string cur_test;
    int fail_count = 0;
    int checked;

    rv_core_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .run          (run),
        .retire       (retire),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .halt         (halt),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // outside the image, opcode field zero so never a legal word
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) & 32'hffff_ff80;
    endfunction

    // combinational program memory
    assign imem_off = (imem_addr - core_cfg_pkg::reset_pc) >> 2;
    assign imem_rdata = (imem_off < prog_len) ? prog[imem_off[7:0]] : fill_word(imem_addr);

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] off;
        off = (addr - core_cfg_pkg::reset_pc) >> 2;
        if (off < prog_len) begin
            return prog[off[7:0]];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // upper lcg bits, low ones cycle too fast
    function automatic int pick(input int n);
        return int'((lcg_next() >> 16) % n);
    endfunction

    task automatic fail_run(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s %s: expected %h actual %h", name, what, exp, act));
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_i(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, rv_isa_pkg::f3_add, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {rv_isa_pkg::f7_add, rs2, rs1, rv_isa_pkg::f3_add, rd, rv_isa_pkg::opc_op};
    endfunction

    function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::opc_jal};
    endfunction

    function automatic void emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endfunction

    // ISA model, runs the image from reset_pc
    function automatic void run_isa_model();
        logic [31:0] regs [rv_isa_pkg::num_regs];
        logic [31:0] pc, inst, imm_i, imm_u, imm_j, val, next_pc;
        logic [4:0] rd;
        logic legal;
        exp_pc.delete();
        exp_rd.delete();
        exp_wdata.delete();
        // stays set unless ebreak is reached
        exp_illegal = 1'b1;
        for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
            regs[i] = '0;
        end
        pc = core_cfg_pkg::reset_pc;
        for (int step = 0; step < 4 * max_words; step++) begin
            inst = mem_word(pc);
            rd = inst[11:7];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_u = {inst[31:12], 12'b0};
            imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            next_pc = pc + 32'd4;
            val = pc + 32'd4;
            legal = (inst[14:12] == rv_isa_pkg::f3_add);
            if (inst == rv_isa_pkg::inst_ebreak) begin
                exp_pc.push_back(pc);
                exp_rd.push_back(0);
                exp_wdata.push_back(0);
                exp_illegal = 1'b0;
                return;
            end
            case (inst[6:0])
                rv_isa_pkg::opc_lui: begin
                    val = imm_u;
                    legal = 1'b1;
                end
                rv_isa_pkg::opc_auipc: begin
                    val = pc + imm_u;
                    legal = 1'b1;
                end
                rv_isa_pkg::opc_jal: begin
                    next_pc = pc + imm_j;
                    legal = 1'b1;
                end
                rv_isa_pkg::opc_jalr: next_pc = (regs[inst[19:15]] + imm_i) & ~32'd1;
                rv_isa_pkg::opc_op_imm: val = regs[inst[19:15]] + imm_i;
                rv_isa_pkg::opc_op: begin
                    val = regs[inst[19:15]] + regs[inst[24:20]];
                    legal = legal && (inst[31:25] == 7'd0);
                end
                default: legal = 1'b0;
            endcase
            // the offending word itself never retires
            if (!legal) begin
                return;
            end
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_wdata.push_back(val);
            if (rd != 0) begin
                regs[rd] = val;
            end
            pc = next_pc;
        end
    endfunction

    // addi and add over x0..x7, often chained on the last rd
    task automatic gen_arith(input int n);
        logic [4:0] rd, rs1, last_rd;
        last_rd = 5'd1;
        for (int i = 0; i < n; i++) begin
            rd = 5'(1 + pick(7));
            rs1 = (pick(3) == 0) ? last_rd : 5'(pick(8));
            if (pick(2) == 0) begin
                emit(enc_i(rv_isa_pkg::opc_op_imm, rd, rs1, 12'(lcg_next())));
            end else begin
                emit(enc_add(rd, rs1, 5'(pick(8))));
            end
            last_rd = rd;
        end
    endtask

    task automatic gen_upper(input int n);
        for (int i = 0; i < n; i++) begin
            case (pick(3))
                0: emit(enc_u(rv_isa_pkg::opc_lui, 5'(1 + pick(7)), 20'(lcg_next())));
                1: emit(enc_u(rv_isa_pkg::opc_auipc, 5'(1 + pick(7)), 20'(lcg_next())));
                default: gen_arith(1);
            endcase
        end
    endtask

    // wrong-path words, any of them would show up if retired
    task automatic fill_skipped(input int k);
        for (int i = 0; i < k; i++) begin
            if (pick(2) == 0) begin
                emit(rv_isa_pkg::inst_ebreak);
            end else begin
                emit(enc_i(rv_isa_pkg::opc_op_imm, 5'(1 + pick(7)), 5'd0, 12'h7ff));
            end
        end
    endtask

    // forward jal, auipc plus jalr with odd offsets, addi in between
    task automatic gen_jumps(input int n);
        int k;
        for (int i = 0; i < n; i++) begin
            k = 1 + pick(3);
            case (pick(3))
                0: begin
                    emit(enc_jal(5'(pick(8)), 21'(4 * (k + 1))));
                    fill_skipped(k);
                end
                1: begin
                    emit(enc_u(rv_isa_pkg::opc_auipc, 5'd6, 20'd0));
                    emit(enc_i(rv_isa_pkg::opc_jalr, 5'(pick(8)), 5'd6, 12'(8 + 4 * k + pick(2))));
                    fill_skipped(k);
                end
                default: gen_arith(1);
            endcase
        end
    endtask

    task automatic gen_x0(input int n);
        for (int i = 0; i < n; i++) begin
            case (pick(4))
                0: emit(enc_i(rv_isa_pkg::opc_op_imm, 5'd0, 5'(pick(8)), 12'(lcg_next())));
                1: emit(enc_u(rv_isa_pkg::opc_lui, 5'd0, 20'(lcg_next())));
                2: emit(enc_add(5'(1 + pick(7)), 5'd0, 5'(1 + pick(7))));
                default: emit(enc_i(rv_isa_pkg::opc_op_imm, 5'(1 + pick(7)), 5'd0, 12'(lcg_next())));
            endcase
        end
    endtask

    // reset, run to halt, then confirm the core stays stopped
    task automatic run_test(input string name, input bit random_run);
        logic [31:0] r;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        run = 1'b0;
        cur_test = name;
        run_isa_model();
        checked = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run = 1'b1;
        while (!halt) begin
            @(posedge clk);
            #1;
            r = lcg_next();
            // run high one cycle in four, so the queue fills
            run = random_run ? (r[17:16] == 2'b00) : 1'b1;
        end
        run = 1'b1;
        repeat (12) @(posedge clk);
        #1;
        check(name, "halt", 32'd1, halt);
        check(name, "illegal", exp_illegal, illegal);
        check(name, "retirements left", 32'd0, exp_pc.size());
        $display("%s: %0d retirements checked", name, checked);
    endtask

    // compare process, outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n && retire) begin
            if (exp_pc.size() == 0) begin
                fail_run($sformatf("%s: retire at pc %h after the model stopped",
                                   cur_test, retire_pc));
            end else begin
                check(cur_test, "retire_pc", exp_pc.pop_front(), retire_pc);
                check(cur_test, "retire_rd", exp_rd.pop_front(), retire_rd);
                check(cur_test, "retire_wdata", exp_wdata.pop_front(), retire_wdata);
                checked++;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        fail_run("timeout: the core did not reach halt within the time allowed");
    end

    initial begin
        rst_n = 1'b0;
        run = 1'b0;
        lcg_state = 32'd61788;
        prog_len = 0;
        gen_arith(40);
        emit(rv_isa_pkg::inst_ebreak);
        run_test("arith", 1'b0);
        prog_len = 0;
        gen_upper(30);
        emit(rv_isa_pkg::inst_ebreak);
        run_test("upper", 1'b0);
        prog_len = 0;
        gen_jumps(10);
        emit(rv_isa_pkg::inst_ebreak);
        run_test("jumps", 1'b0);
        prog_len = 0;
        gen_x0(30);
        emit(rv_isa_pkg::inst_ebreak);
        run_test("x0", 1'b0);
        // same image twice, steady run then stalls
        prog_len = 0;
        gen_arith(10);
        gen_jumps(8);
        emit(rv_isa_pkg::inst_ebreak);
        run_test("backpressure_run_high", 1'b0);
        run_test("backpressure_random_run", 1'b1);
        // custom-0 opcode in the middle
        prog_len = 0;
        gen_arith(8);
        emit({25'(lcg_next()), 7'b0001011});
        gen_arith(4);
        emit(rv_isa_pkg::inst_ebreak);
        run_test("illegal", 1'b0);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/rv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/fetch_queue_if.sv
rtl/inst_fetch.sv
rtl/fetch_queue.sv
rtl/int_regfile.sv
rtl/rv_exec.sv
rtl/rv_core_top.sv
testbench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/core_cfg_pkg.sv
  - rtl/fetch_queue_if.sv
  - rtl/inst_fetch.sv
  - rtl/fetch_queue.sv
  - rtl/int_regfile.sv
  - rtl/rv_exec.sv
  - rtl/rv_core_top.sv
  - target: test
    files:
      - testbench/tb_rv_core.sv
